//--- include/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// address bits that pick a target
`define BUS_SEL_HI 31
`define BUS_SEL_LO 28

// agent counts
`define BUS_MASTERS 4
`define BUS_SLAVES  4

// select nibble of slave 0; slave k sits at base + k
`define BUS_SLAVE_BASE 8

`endif

//--- logic/bus_pkg.sv
`include "bus_config.svh"

package bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0] addr_t;
    typedef logic [`BUS_DATA_W-1:0] data_t;

    typedef logic [$clog2(`BUS_MASTERS)-1:0] master_id_t;
    typedef logic [$clog2(`BUS_SLAVES)-1:0]  slave_id_t;

    // outgoing signals of one master
    typedef struct packed {
        addr_t read_addr;
        logic  read_en;
        addr_t write_addr;
        data_t write_data;
        logic  write_en;
    } master_req_t;

    // incoming signals of one slave, same layout as a request
    typedef struct packed {
        addr_t read_addr;
        logic  read_en;
        addr_t write_addr;
        data_t write_data;
        logic  write_en;
    } slave_port_t;

    // decoded targets of the granted request
    typedef struct packed {
        logic      read_hit;    // read nibble in slave range
        slave_id_t read_slave;
        logic      write_hit;   // write nibble in slave range
        slave_id_t write_slave;
    } target_t;

endpackage

//--- logic/bus_grant.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module bus_grant (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`BUS_MASTERS-1:0] bus_req,
    output bus_pkg::master_id_t     grant
);

    bus_pkg::master_id_t next_grant;

    // top-down scan so the lowest request lands last
    always_comb begin
        next_grant = '0;    // idle bus parks on master 0
        for (int i = `BUS_MASTERS - 1; i >= 0; i--) begin
            if (bus_req[i]) begin
                next_grant = bus_pkg::master_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= '0;
        end else begin
            grant <= next_grant;
        end
    end

endmodule

//--- logic/target_decode.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module target_decode (
    input  bus_pkg::master_id_t  grant,
    input  bus_pkg::master_req_t master_req [`BUS_MASTERS],
    output bus_pkg::master_req_t active,
    output bus_pkg::target_t     target
);

    localparam int SEL_W = `BUS_SEL_HI - `BUS_SEL_LO + 1;

    logic [SEL_W-1:0] read_offset;
    logic [SEL_W-1:0] write_offset;

    // select nibble relative to slave 0; wraps for nibbles below base
    function automatic logic [SEL_W-1:0] sel_offset(input bus_pkg::addr_t addr);
        logic [SEL_W-1:0] nibble;
        nibble = addr[`BUS_SEL_HI:`BUS_SEL_LO];
        return nibble - SEL_W'(`BUS_SLAVE_BASE);
    endfunction

    function automatic logic sel_hit(input logic [SEL_W-1:0] offset);
        return offset < SEL_W'(`BUS_SLAVES);
    endfunction

    assign active = master_req[grant];  // granted master owns the bus

    assign read_offset  = sel_offset(active.read_addr);
    assign write_offset = sel_offset(active.write_addr);

    always_comb begin
        target.read_hit    = sel_hit(read_offset);
        target.read_slave  = bus_pkg::slave_id_t'(read_offset);
        target.write_hit   = sel_hit(write_offset);
        target.write_slave = bus_pkg::slave_id_t'(write_offset);
    end

endmodule

//--- logic/slave_route.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module slave_route (
    input  bus_pkg::master_id_t  grant,
    input  bus_pkg::master_req_t active,
    input  bus_pkg::target_t     target,
    input  bus_pkg::data_t       slave_read_data [`BUS_SLAVES],
    output bus_pkg::slave_port_t slave_port [`BUS_SLAVES],
    output bus_pkg::data_t       master_read_data [`BUS_MASTERS]
);

    logic [`BUS_SLAVES-1:0] read_sel;
    logic [`BUS_SLAVES-1:0] write_sel;

    // one-hot slave selects per direction
    always_comb begin
        read_sel  = '0;
        write_sel = '0;
        for (int k = 0; k < `BUS_SLAVES; k++) begin
            if (target.read_hit && target.read_slave == bus_pkg::slave_id_t'(k)) begin
                read_sel[k] = 1'b1;
            end
            if (target.write_hit && target.write_slave == bus_pkg::slave_id_t'(k)) begin
                write_sel[k] = 1'b1;
            end
        end
    end

    // unselected slave ports stay all zero
    always_comb begin
        for (int k = 0; k < `BUS_SLAVES; k++) begin
            slave_port[k] = '0;
            if (read_sel[k]) begin
                slave_port[k].read_addr = active.read_addr;
                slave_port[k].read_en   = active.read_en;
            end
            if (write_sel[k]) begin
                slave_port[k].write_addr = active.write_addr;
                slave_port[k].write_data = active.write_data;
                slave_port[k].write_en   = active.write_en;
            end
        end
    end

    // read data back to the granted master only
    always_comb begin
        for (int m = 0; m < `BUS_MASTERS; m++) begin
            master_read_data[m] = '0;
        end
        if (target.read_hit) begin
            master_read_data[grant] = slave_read_data[target.read_slave];
        end
    end

endmodule

//--- logic/bus_fabric.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module bus_fabric (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`BUS_MASTERS-1:0] bus_req,
    input  bus_pkg::master_req_t    master_req [`BUS_MASTERS],
    input  bus_pkg::data_t          slave_read_data [`BUS_SLAVES],
    output bus_pkg::slave_port_t    slave_port [`BUS_SLAVES],
    output bus_pkg::data_t          master_read_data [`BUS_MASTERS],
    output bus_pkg::master_id_t     grant
);

    bus_pkg::master_req_t active;   // request of the granted master
    bus_pkg::target_t     target;

    bus_grant u_grant (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .grant   (grant)
    );

    target_decode u_decode (
        .grant      (grant),
        .master_req (master_req),
        .active     (active),
        .target     (target)
    );

    slave_route u_route (
        .grant            (grant),
        .active           (active),
        .target           (target),
        .slave_read_data  (slave_read_data),
        .slave_port       (slave_port),
        .master_read_data (master_read_data)
    );

endmodule

//--- test/bus_fabric_tb.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module bus_fabric_tb;

    // one line of the stimulus file
    typedef struct packed {
        logic [`BUS_MASTERS-1:0] mask;
        bus_pkg::addr_t          read_addr;
        bus_pkg::addr_t          write_addr;
        bus_pkg::data_t          write_data;
        logic                    read_en;
        logic                    write_en;
        bus_pkg::master_id_t     exp_grant;
    } vector_t;

    logic                    clk;
    logic                    rst_n;
    logic [`BUS_MASTERS-1:0] bus_req;
    bus_pkg::master_req_t    master_req [`BUS_MASTERS];
    bus_pkg::data_t          slave_read_data [`BUS_SLAVES];
    bus_pkg::slave_port_t    slave_port [`BUS_SLAVES];
    bus_pkg::data_t          master_read_data [`BUS_MASTERS];
    bus_pkg::master_id_t     grant;

    vector_t             vectors [$];
    bus_pkg::master_id_t prev_grant;   // grant owed to the vector before
    int                  errors = 0;
    int                  checks = 0;
    bit                  loaded = 1'b0;

    bus_fabric dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .bus_req          (bus_req),
        .master_req       (master_req),
        .slave_read_data  (slave_read_data),
        .slave_port       (slave_port),
        .master_read_data (master_read_data),
        .grant            (grant)
    );

    initial clk = 1'b0;

    always begin
        #50 clk = ~clk;
    end

    // slave k answers its read address xor k
    always_comb begin
        for (int k = 0; k < `BUS_SLAVES; k++) begin
            slave_read_data[k] = slave_port[k].read_addr ^ bus_pkg::data_t'(k);
        end
    end

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f_mask;
        logic [31:0] f_raddr;
        logic [31:0] f_waddr;
        logic [31:0] f_wdata;
        logic [31:0] f_ren;
        logic [31:0] f_wen;
        logic [31:0] f_grant;
        vector_t     v;
        fd = $fopen("test/bus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open test/bus_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin   // skip comments and blanks
                    fields = $sscanf(line, "%h %h %h %h %h %h %h", f_mask, f_raddr,
                                     f_waddr, f_wdata, f_ren, f_wen, f_grant);
                    if (fields == 7) begin
                        v.mask       = f_mask[`BUS_MASTERS-1:0];
                        v.read_addr  = f_raddr;
                        v.write_addr = f_waddr;
                        v.write_data = f_wdata;
                        v.read_en    = f_ren[0];
                        v.write_en   = f_wen[0];
                        v.exp_grant  = bus_pkg::master_id_t'(f_grant);
                        vectors.push_back(v);
                    end else begin
                        errors++;
                        $display("stimulus line has %0d fields instead of 7: %s", fields, line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_vector(input vector_t v);
        bus_req = v.mask;
        for (int m = 0; m < `BUS_MASTERS; m++) begin
            master_req[m].read_addr  = v.read_addr;
            master_req[m].read_en    = v.read_en;
            master_req[m].write_addr = v.write_addr;
            master_req[m].write_data = v.write_data ^ bus_pkg::data_t'(m);  // tags the source
            master_req[m].write_en   = v.write_en;
        end
    endtask

    task automatic check_outputs(input vector_t v);
        int   read_slave;
        int   write_slave;
        logic read_hit;
        logic write_hit;
        logic sel;
        read_slave  = int'(v.read_addr[`BUS_SEL_HI:`BUS_SEL_LO]) - `BUS_SLAVE_BASE;
        write_slave = int'(v.write_addr[`BUS_SEL_HI:`BUS_SEL_LO]) - `BUS_SLAVE_BASE;
        read_hit    = read_slave >= 0 && read_slave < `BUS_SLAVES;
        write_hit   = write_slave >= 0 && write_slave < `BUS_SLAVES;
        compare_value(32'(grant), 32'(v.exp_grant), "grant");
        for (int k = 0; k < `BUS_SLAVES; k++) begin
            sel = read_hit && read_slave == k;
            compare_value(32'(slave_port[k].read_en), sel ? 32'(v.read_en) : 32'd0,
                          $sformatf("slave %0d read_en", k));
            compare_value(slave_port[k].read_addr, sel ? v.read_addr : '0,
                          $sformatf("slave %0d read_addr", k));
            sel = write_hit && write_slave == k;
            compare_value(32'(slave_port[k].write_en), sel ? 32'(v.write_en) : 32'd0,
                          $sformatf("slave %0d write_en", k));
            compare_value(slave_port[k].write_addr, sel ? v.write_addr : '0,
                          $sformatf("slave %0d write_addr", k));
            compare_value(slave_port[k].write_data,
                          sel ? v.write_data ^ bus_pkg::data_t'(v.exp_grant) : '0,
                          $sformatf("slave %0d write_data", k));
        end
        for (int m = 0; m < `BUS_MASTERS; m++) begin
            sel = read_hit && m == int'(v.exp_grant);   // only the owner hears back
            compare_value(master_read_data[m],
                          sel ? v.read_addr ^ bus_pkg::data_t'(read_slave) : '0,
                          $sformatf("master %0d read data", m));
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        bus_req    = '0;
        prev_grant = '0;
        for (int m = 0; m < `BUS_MASTERS; m++) begin
            master_req[m] = '0;
        end
        load_vectors();
        if (vectors.size() == 0) begin
            $display("no vectors loaded from the stimulus file");
            $display("sim failed");
            $finish;
        end else begin
            loaded  = 1'b1;
            bus_req = 4'b1110;   // pending requests must not move the grant in reset
            repeat (16) begin
                @(posedge clk);
                #10;
                compare_value(32'(grant), 32'd0, "grant during reset");
            end
            foreach (vectors[i]) begin
                @(negedge clk);
                rst_n = 1'b1;
                drive_vector(vectors[i]);
                #10;
                // new requests wait for the edge
                compare_value(32'(grant), 32'(prev_grant), "grant before the edge");
                @(posedge clk);
                #10;
                check_outputs(vectors[i]);
                prev_grant = vectors[i].exp_grant;
            end
            $display("vectors %0d, checks %0d, errors %0d", vectors.size(), checks, errors);
            if (errors == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

    // watchdog covers reset, every vector and some slack
    initial begin
        wait (loaded);
        #((vectors.size() + 16 + 10) * 100);
        $display("timeout: run did not finish within %0d cycles", vectors.size() + 26);
        $display("sim failed");
        $finish;
    end

endmodule

//--- test/bus_stimulus.txt
# columns: request mask, read addr, write addr, write data, read en, write en, expected grant
# all hex; grant is the lowest set bit of the mask applied in the same line
# idle bus right after reset
0 00000000 00000000 00000000 0 0 0
# one master at a time, one slave each
1 80000010 80000100 11110000 1 1 0
2 90000020 90000200 22220000 1 1 1
4 a0000030 a0000300 33330000 1 1 2
8 b0000040 b0000400 44440000 1 1 3
# several masters compete
3 b1234567 8abcdef0 deadbeef 1 1 0
6 a0001000 b0002000 cafef00d 1 1 1
c 9ffffffc 80000008 0badc0de 1 1 2
e 8000000c a0000010 12345678 1 0 1
# unmapped nibbles, low and high
f 00001000 70000000 55555555 1 1 0
8 c0000000 f0000000 aaaaaaaa 1 1 3
4 70000000 c0000004 13579bdf 1 1 2
# mapped read with enable low still returns data
2 80000000 00000000 00000000 0 0 1
# empty mask parks on master 0
0 b0000000 b0000000 ffffffff 1 1 0
a 90000044 a0000044 01020304 0 1 1
5 a0000048 90000048 05060708 1 0 0
9 b000004c 8000004c 090a0b0c 1 1 0
8 8000fff0 8000fff0 0d0e0f10 1 1 3
6 b0000050 b0000050 11121314 1 1 1
c 10000000 80000060 15161718 1 1 2
7 a0000064 20000064 191a1b1c 1 1 0
b 30000068 b0000068 1d1e1f20 1 1 0
d e000006c d000006c 21222324 1 1 0
8 90000070 90000070 25262728 0 1 3
4 a0000074 a0000074 292a2b2c 1 0 2
2 b0000078 b0000078 2d2e2f30 1 1 1
1 8000007c 8000007c 31323334 1 1 0
0 90000080 a0000080 35363738 1 1 0
f a0000084 90000084 393a3b3c 1 1 0
e 80000088 b0000088 3d3e3f40 1 1 1
# edges of the slave range
c 7ffffffc bfffffff 41424344 1 1 2
8 bffffffc 7fffffff 45464748 1 1 3
a 40000090 50000090 494a4b4c 1 1 1
6 a0000094 60000094 4d4e4f50 1 1 1
# back to idle
0 00000000 00000000 00000000 0 0 0

//--- tb.f
+incdir+include
logic/bus_pkg.sv
logic/bus_grant.sv
logic/target_decode.sv
logic/slave_route.sv
logic/bus_fabric.sv
test/bus_fabric_tb.sv

//--- run.sh
#!/bin/sh
# build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module bus_fabric_tb -Mdir build -o bus_fabric_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./build/bus_fabric_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
